// File: simple_risc.f
+incdir+source
source/simple_risc_pkg.sv
source/fetch_decode.sv
source/control_fsm.sv
source/register_file.sv
source/alu_shifter.sv
source/datapath.sv
source/simple_risc_cpu.sv
test/tb_clock_gen.sv
test/simple_risc_tb.sv

// File: test/simple_risc_tb.sv
// simple risc testbench, program memory, reference model and checks against the core
`timescale 1ns/1ps
`include "simple_risc_config.svh"

module simple_risc_tb;

    localparam int                    CLK_PERIOD_NS = 100;
    localparam logic [`SR_ADDR_W-1:0] START_PC      = 8'h10;
    localparam int                    RAND_INSTRS   = 40;

    logic                           clk;
    logic                           rst_n;
    logic [`SR_ADDR_W-1:0]          start_pc;
    logic [`SR_WORD_W-1:0]          mem_rdata;
    logic [`SR_ADDR_W-1:0]          mem_addr;
    logic [`SR_WORD_W-1:0]          out;
    simple_risc_pkg::status_flags_t flags;
    logic                           halted;

    logic [`SR_WORD_W-1:0]          mem [2**`SR_ADDR_W];
    logic [`SR_WORD_W-1:0]          model_regs [`SR_NUM_REGS];
    logic [`SR_WORD_W-1:0]          model_c;
    simple_risc_pkg::status_flags_t model_flags;
    logic [31:0]                    rng_state;
    logic [`SR_ADDR_W-1:0]          cur_addr;    // instruction now running
    int                             prog_len;
    int                             cyc_count;
    bit                             prog_ready;
    bit                             tracking;
    bit                             halt_seen;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk (.clk(clk));

    simple_risc_cpu UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_pc  (start_pc),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .out       (out),
        .flags     (flags),
        .halted    (halted)
    );

    // program memory, word comes back one edge after the address
    always @(posedge clk) begin
        mem_rdata <= mem[mem_addr];
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string msg);
        fail_run($sformatf("ERR %0d ns: %s", $time, msg));
    endtask

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [15:0] mov_imm(input logic [2:0] rn, input logic [7:0] imm);
        return {3'b110, 2'b10, rn, imm};
    endfunction

    function automatic logic [15:0] mov_reg(input logic [2:0] rd, input logic [1:0] sh,
                                            input logic [2:0] rm);
        return {3'b110, 2'b00, 3'b000, rd, sh, rm};
    endfunction

    function automatic logic [15:0] alu_instr(input logic [1:0] op, input logic [2:0] rn,
                                              input logic [2:0] rd, input logic [1:0] sh,
                                              input logic [2:0] rm);
        return {3'b101, op, rn, rd, sh, rm};
    endfunction

    task automatic put_word(input logic [15:0] w);
        mem[START_PC + prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] r;
        // unused words decode as halt, low byte carries the address
        for (int i = 0; i < 2**`SR_ADDR_W; i++) begin
            mem[i] = {3'b111, 5'h15, i[7:0]};
        end
        put_word(mov_imm(3'd0, 8'h05));
        put_word(mov_imm(3'd1, 8'h80));                        // 0xff80
        put_word(mov_imm(3'd2, 8'h7f));
        put_word(mov_imm(3'd3, 8'hfe));
        put_word(mov_imm(3'd4, 8'h01));
        put_word(mov_imm(3'd5, 8'h40));
        put_word(mov_imm(3'd6, 8'hc3));
        put_word(mov_imm(3'd7, 8'h2a));
        put_word(mov_reg(3'd2, 2'b10, 3'd1));                  // r2 = 0x7fc0
        put_word(mov_reg(3'd3, 2'b11, 3'd6));
        put_word(mov_reg(3'd4, 2'b01, 3'd5));
        put_word(mov_reg(3'd5, 2'b00, 3'd0));
        put_word(alu_instr(2'b11, 3'd0, 3'd6, 2'b00, 3'd2));   // r6 = 0x803f
        // cmp overflow both ways, then equal and negative
        put_word(alu_instr(2'b01, 3'd2, 3'd0, 2'b00, 3'd1));
        put_word(alu_instr(2'b01, 3'd6, 3'd0, 2'b00, 3'd2));
        put_word(alu_instr(2'b01, 3'd0, 3'd0, 2'b00, 3'd5));
        put_word(alu_instr(2'b01, 3'd0, 3'd0, 2'b00, 3'd7));
        put_word(alu_instr(2'b00, 3'd0, 3'd7, 2'b01, 3'd4));
        put_word(alu_instr(2'b10, 3'd3, 3'd3, 2'b00, 3'd1));
        for (int i = 0; i < RAND_INSTRS; i++) begin
            r = next_rand();
            case (r[31:29])
                3'd0, 3'd1: put_word(mov_imm(r[28:26], r[17:10]));
                3'd2:       put_word(mov_reg(r[25:23], r[22:21], r[20:18]));
                3'd3, 3'd4: put_word(alu_instr(2'b00, r[28:26], r[25:23], r[22:21], r[20:18]));
                3'd5:       put_word(alu_instr(2'b10, r[28:26], r[25:23], r[22:21], r[20:18]));
                3'd6:       put_word(alu_instr(2'b11, r[28:26], r[25:23], r[22:21], r[20:18]));
                default:    put_word(alu_instr(2'b01, r[28:26], r[25:23], r[22:21], r[20:18]));
            endcase
        end
        put_word(16'he000);
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic logic [15:0] shift_operand(input logic [15:0] b, input logic [1:0] sh);
        case (sh)
            2'b01:   return b << 1;
            2'b10:   return b >> 1;
            2'b11:   return $signed(b) >>> 1;
            default: return b;
        endcase
    endfunction

    // pc_update, fetch_wait, load_ir and decode, then execute
    function automatic int expected_cycles(input logic [15:0] w);
        if (w[15:13] == simple_risc_pkg::OP_MOV) begin
            return (w[12:11] == 2'b10) ? 4 + 1 : 4 + 3;
        end
        case (w[12:11])
            2'b00, 2'b10: return 4 + 4;   // add, and
            default:      return 4 + 3;   // mvn, cmp
        endcase
    endfunction

    task automatic apply_model(input logic [15:0] w);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] diff;
        a = model_regs[w[10:8]];
        b = shift_operand(model_regs[w[2:0]], w[4:3]);
        if (w[15:13] == simple_risc_pkg::OP_MOV && w[12:11] == 2'b10) begin
            model_regs[w[10:8]] = {{8{w[7]}}, w[7:0]};
        end else if (w[15:13] == simple_risc_pkg::OP_MOV) begin
            model_c            = b;
            model_regs[w[7:5]] = b;
        end else begin
            case (w[12:11])
                2'b00:   model_c = a + b;
                2'b10:   model_c = a & b;
                2'b11:   model_c = ~b;
                default: begin
                    diff          = a - b;
                    model_flags.z = (diff == 16'h0000);
                    model_flags.n = diff[15];
                    model_flags.v = (a[15] != b[15]) && (diff[15] != a[15]);
                end
            endcase
            if (w[12:11] != 2'b01) model_regs[w[7:5]] = model_c;
        end
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (tracking && !halt_seen) begin
            cyc_count++;
            if (halted) begin
                assert (mem[cur_addr][15:13] == simple_risc_pkg::OP_HALT && cyc_count == 3 &&
                        cur_addr == START_PC + prog_len - 1)
                    else value_error($sformatf("halted at %h after %0d cycles", cur_addr,
                                               cyc_count));
                halt_seen = 1'b1;
            end else if (mem_addr !== cur_addr) begin
                // the count already holds the first cycle of the next instruction
                assert (mem_addr === cur_addr + 1'b1)
                    else value_error($sformatf("mem_addr %h after %h", mem_addr, cur_addr));
                assert (cyc_count - 1 == expected_cycles(mem[cur_addr]))
                    else value_error($sformatf("instr %h took %0d cycles, expected %0d",
                                               mem[cur_addr], cyc_count - 1,
                                               expected_cycles(mem[cur_addr])));
                apply_model(mem[cur_addr]);
                assert (out === model_c)
                    else value_error($sformatf("out %h, expected %h after instr %h",
                                               out, model_c, mem[cur_addr]));
                assert (flags === model_flags)
                    else value_error($sformatf("flags %b, expected %b after instr %h",
                                               flags, model_flags, mem[cur_addr]));
                cur_addr  = mem_addr;
                cyc_count = 1;
            end
        end
    end

    a_halt_frozen: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |=> halted && $stable(mem_addr) && $stable(out) && $stable(flags)
    ) else value_error("core state moved after halted was raised");

    initial begin : watchdog
        wait (prog_ready);
        #((prog_len * 12 + 50) * CLK_PERIOD_NS);
        fail_run("timeout, the core did not halt within the expected number of cycles");
    end

    initial begin
        rst_n       = 1'b0;
        start_pc    = START_PC;
        mem_rdata   = '0;
        rng_state   = 32'hc54b2444;
        model_c     = '0;
        model_flags = '0;
        cur_addr    = START_PC;
        prog_len    = 0;
        cyc_count   = 0;
        tracking    = 1'b0;
        halt_seen   = 1'b0;
        build_program();
        prog_ready  = 1'b1;
        repeat (10) @(posedge clk);
        rst_n     <= 1'b1;
        cyc_count = -1;     // reset cycle stands in for the first pc_update
        tracking  = 1'b1;
        @(negedge clk);
        assert (!halted && out === '0 && flags === '0 && mem_addr === START_PC)
            else value_error("core not in its reset state after reset release");
        wait (halt_seen);
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (halted && mem_addr === cur_addr && out === model_c && flags === model_flags)
                else value_error($sformatf("core moved %0d cycles after halt", i + 1));
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: test/tb_clock_gen.sv
// testbench clock source, free running square wave
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2) clk = ~clk;   // half period high, half low
    end

endmodule

// File: source/simple_risc_cpu.sv
// simple risc core top, connects fetch/decode, controller and datapath
`timescale 1ns/1ps
`include "simple_risc_config.svh"

module simple_risc_cpu (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [`SR_ADDR_W-1:0]          start_pc,
    input  logic [`SR_WORD_W-1:0]          mem_rdata,
    output logic [`SR_ADDR_W-1:0]          mem_addr,
    output logic [`SR_WORD_W-1:0]          out,
    output simple_risc_pkg::status_flags_t flags,
    output logic                           halted
);

    simple_risc_pkg::decoded_instr_t instr;
    simple_risc_pkg::dp_ctrl_t       ctrl;
    logic                            load_pc;
    logic                            clear_pc;
    logic                            load_ir;

    fetch_decode u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_pc  (start_pc),
        .mem_rdata (mem_rdata),
        .load_pc   (load_pc),
        .clear_pc  (clear_pc),
        .load_ir   (load_ir),
        .mem_addr  (mem_addr),
        .instr     (instr)
    );

    control_fsm u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .load_pc  (load_pc),
        .clear_pc (clear_pc),
        .load_ir  (load_ir),
        .ctrl     (ctrl),
        .halted   (halted)
    );

    datapath u_dp (
        .clk   (clk),
        .rst_n (rst_n),
        .instr (instr),
        .ctrl  (ctrl),
        .out   (out),
        .flags (flags)
    );

endmodule

// File: source/datapath.sv
// execution datapath, operand registers, register file, alu and result/status registers
`timescale 1ns/1ps
`include "simple_risc_config.svh"

module datapath (
    input  logic                            clk,
    input  logic                            rst_n,
    input  simple_risc_pkg::decoded_instr_t instr,
    input  simple_risc_pkg::dp_ctrl_t       ctrl,
    output logic [`SR_WORD_W-1:0]           out,
    output simple_risc_pkg::status_flags_t  flags
);

    logic [`SR_REG_IDX_W-1:0]       reg_idx;
    logic [`SR_WORD_W-1:0]          wb_data;
    logic [`SR_WORD_W-1:0]          r_data;
    logic [`SR_WORD_W-1:0]          a_reg;
    logic [`SR_WORD_W-1:0]          b_reg;
    logic [`SR_WORD_W-1:0]          c_reg;
    logic [`SR_WORD_W-1:0]          a_val;
    logic [`SR_WORD_W-1:0]          alu_result;
    simple_risc_pkg::status_flags_t alu_flags;
    simple_risc_pkg::status_flags_t status;

    // one index for both read and write
    always_comb begin
        case (ctrl.reg_sel)
            simple_risc_pkg::REG_RM: reg_idx = instr.rm;
            simple_risc_pkg::REG_RD: reg_idx = instr.rd;
            default:                 reg_idx = instr.rn;
        endcase
    end

    assign wb_data = ctrl.wb_imm ? instr.sximm8 : c_reg;

    register_file u_regs (
        .clk    (clk),
        .w_data (wb_data),
        .w_addr (reg_idx),
        .w_en   (ctrl.reg_wr),
        .r_addr (reg_idx),
        .r_data (r_data)
    );

    //////////////////////////////////////////////////
    // operands and alu
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ctrl.load_a) a_reg <= r_data;
        if (ctrl.load_b) b_reg <= r_data;
    end

    assign a_val = ctrl.zero_a ? '0 : a_reg;

    alu_shifter u_alu (
        .a_val    (a_val),
        .b_raw    (b_reg),
        .shift_op (instr.shift_op),
        .alu_op   (instr.alu_op),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    // result and status, visible at the core ports
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            c_reg  <= '0;
            status <= '0;
        end else begin
            if (ctrl.load_c)      c_reg  <= alu_result;
            if (ctrl.load_status) status <= alu_flags;
        end
    end

    assign out   = c_reg;
    assign flags = status;

    a_wr_not_with_c: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctrl.reg_wr && ctrl.load_c)
    );

endmodule

// File: source/alu_shifter.sv
// operand shifter followed by the alu, with zero, negative and overflow flags
`timescale 1ns/1ps
`include "simple_risc_config.svh"

module alu_shifter (
    input  logic [`SR_WORD_W-1:0]          a_val,
    input  logic [`SR_WORD_W-1:0]          b_raw,
    input  simple_risc_pkg::shift_op_e     shift_op,
    input  simple_risc_pkg::alu_op_e       alu_op,
    output logic [`SR_WORD_W-1:0]          result,
    output simple_risc_pkg::status_flags_t flags
);

    localparam int MSB = `SR_WORD_W - 1;

    logic [`SR_WORD_W-1:0] b_shifted;

    // one bit shifts only
    always_comb begin
        case (shift_op)
            simple_risc_pkg::SH_NONE: b_shifted = b_raw;
            simple_risc_pkg::SH_LSL:  b_shifted = {b_raw[MSB-1:0], 1'b0};
            simple_risc_pkg::SH_LSR:  b_shifted = {1'b0, b_raw[MSB:1]};
            simple_risc_pkg::SH_ASR:  b_shifted = {b_raw[MSB], b_raw[MSB:1]};
            default:                  b_shifted = b_raw;
        endcase
    end

    always_comb begin
        case (alu_op)
            simple_risc_pkg::ALU_ADD: result = a_val + b_shifted;
            simple_risc_pkg::ALU_CMP: result = a_val - b_shifted;
            simple_risc_pkg::ALU_AND: result = a_val & b_shifted;
            simple_risc_pkg::ALU_MVN: result = ~b_shifted;
            default:                  result = b_shifted;
        endcase
    end

    //////////////////////////////////////////////////
    // flags
    //////////////////////////////////////////////////

    always_comb begin
        flags.z = (result == '0);
        flags.n = result[MSB];
        case (alu_op)
            // same sign in, other sign out
            simple_risc_pkg::ALU_ADD:
                flags.v = (a_val[MSB] == b_shifted[MSB]) && (result[MSB] != a_val[MSB]);
            simple_risc_pkg::ALU_CMP:
                flags.v = (a_val[MSB] != b_shifted[MSB]) && (result[MSB] != a_val[MSB]);
            default:
                flags.v = 1'b0;
        endcase
    end

endmodule

// File: source/register_file.sv
// general purpose register file, one synchronous write port and one async read port
`timescale 1ns/1ps
`include "simple_risc_config.svh"

module register_file (
    input  logic                     clk,
    input  logic [`SR_WORD_W-1:0]    w_data,
    input  logic [`SR_REG_IDX_W-1:0] w_addr,
    input  logic                     w_en,
    input  logic [`SR_REG_IDX_W-1:0] r_addr,
    output logic [`SR_WORD_W-1:0]    r_data
);

    logic [`SR_WORD_W-1:0] regs [`SR_NUM_REGS];

    // write on the clock edge
    always_ff @(posedge clk) begin
        if (w_en) begin
            regs[w_addr] <= w_data;
        end
    end

    // read is combinational, new value visible the cycle after a write
    assign r_data = regs[r_addr];

endmodule

// File: source/control_fsm.sv
// multi-cycle controller, sequences fetch, decode and execute steps per instruction
`timescale 1ns/1ps

module control_fsm (
    input  logic                            clk,
    input  logic                            rst_n,
    input  simple_risc_pkg::decoded_instr_t instr,
    output logic                            load_pc,
    output logic                            clear_pc,
    output logic                            load_ir,
    output simple_risc_pkg::dp_ctrl_t       ctrl,
    output logic                            halted
);

    simple_risc_pkg::cpu_state_e state;
    simple_risc_pkg::cpu_state_e next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= simple_risc_pkg::S_RESET;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            simple_risc_pkg::S_RESET:      next_state = simple_risc_pkg::S_FETCH_WAIT;
            simple_risc_pkg::S_PC_UPDATE:  next_state = simple_risc_pkg::S_FETCH_WAIT;
            simple_risc_pkg::S_FETCH_WAIT: next_state = simple_risc_pkg::S_LOAD_IR;
            simple_risc_pkg::S_LOAD_IR:    next_state = simple_risc_pkg::S_DECODE;
            simple_risc_pkg::S_DECODE: begin
                case (instr.opcode)
                    simple_risc_pkg::OP_MOV: begin
                        // 10 is mov immediate, 00 mov register
                        if (instr.alu_op == simple_risc_pkg::ALU_AND)
                            next_state = simple_risc_pkg::S_WRITE_IMM;
                        else if (instr.alu_op == simple_risc_pkg::ALU_ADD)
                            next_state = simple_risc_pkg::S_LOAD_B;
                        else
                            next_state = simple_risc_pkg::S_HALT;
                    end
                    simple_risc_pkg::OP_ALU: next_state = simple_risc_pkg::S_LOAD_B;
                    default:                 next_state = simple_risc_pkg::S_HALT; // halt or unknown
                endcase
            end
            simple_risc_pkg::S_LOAD_B: begin
                if (instr.opcode == simple_risc_pkg::OP_MOV)
                    next_state = simple_risc_pkg::S_CALC_ZA;
                else if (instr.alu_op == simple_risc_pkg::ALU_MVN)
                    next_state = simple_risc_pkg::S_CALC;    // mvn ignores A
                else
                    next_state = simple_risc_pkg::S_LOAD_A;
            end
            simple_risc_pkg::S_LOAD_A: begin
                if (instr.alu_op == simple_risc_pkg::ALU_CMP)
                    next_state = simple_risc_pkg::S_LOAD_STATUS;
                else
                    next_state = simple_risc_pkg::S_CALC;
            end
            simple_risc_pkg::S_CALC,
            simple_risc_pkg::S_CALC_ZA:     next_state = simple_risc_pkg::S_WRITE_C;
            simple_risc_pkg::S_WRITE_IMM,
            simple_risc_pkg::S_WRITE_C,
            simple_risc_pkg::S_LOAD_STATUS: next_state = simple_risc_pkg::S_PC_UPDATE;
            simple_risc_pkg::S_HALT:        next_state = simple_risc_pkg::S_HALT;
            default:                        next_state = simple_risc_pkg::S_HALT;
        endcase
    end

    //////////////////////////////////////////////////
    // moore controls
    //////////////////////////////////////////////////

    always_comb begin
        load_pc  = 1'b0;
        clear_pc = 1'b0;
        load_ir  = 1'b0;
        ctrl     = '0;
        case (state)
            simple_risc_pkg::S_RESET: begin
                load_pc  = 1'b1;     // pc takes start_pc
                clear_pc = 1'b1;
            end
            simple_risc_pkg::S_PC_UPDATE: load_pc = 1'b1;
            simple_risc_pkg::S_LOAD_IR:   load_ir = 1'b1;
            simple_risc_pkg::S_WRITE_IMM: begin
                ctrl.reg_sel = simple_risc_pkg::REG_RN;
                ctrl.wb_imm  = 1'b1;
                ctrl.reg_wr  = 1'b1;
            end
            simple_risc_pkg::S_LOAD_B: begin
                ctrl.reg_sel = simple_risc_pkg::REG_RM;
                ctrl.load_b  = 1'b1;
            end
            simple_risc_pkg::S_LOAD_A: begin
                ctrl.reg_sel = simple_risc_pkg::REG_RN;
                ctrl.load_a  = 1'b1;
            end
            simple_risc_pkg::S_CALC:      ctrl.load_c = 1'b1;
            simple_risc_pkg::S_CALC_ZA: begin
                ctrl.zero_a = 1'b1;  // mov passes shifted B through the adder
                ctrl.load_c = 1'b1;
            end
            simple_risc_pkg::S_WRITE_C: begin
                ctrl.reg_sel = simple_risc_pkg::REG_RD;
                ctrl.reg_wr  = 1'b1;
            end
            simple_risc_pkg::S_LOAD_STATUS: ctrl.load_status = 1'b1;
            default: ;
        endcase
    end

    // halted shows already in the decode cycle that leads to halt
    assign halted = (state == simple_risc_pkg::S_HALT) ||
                    (state == simple_risc_pkg::S_DECODE && next_state == simple_risc_pkg::S_HALT);

    a_one_operand_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.load_a, ctrl.load_b, ctrl.load_c})
    );

    // once halted the core stays idle
    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |=> halted && !load_pc && !load_ir && ctrl == '0
    );

endmodule

// File: source/fetch_decode.sv
// instruction fetch side, program counter, instruction register and field decode
`timescale 1ns/1ps
`include "simple_risc_config.svh"

module fetch_decode (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [`SR_ADDR_W-1:0]           start_pc,
    input  logic [`SR_WORD_W-1:0]           mem_rdata,
    input  logic                            load_pc,
    input  logic                            clear_pc,
    input  logic                            load_ir,
    output logic [`SR_ADDR_W-1:0]           mem_addr,
    output simple_risc_pkg::decoded_instr_t instr
);

    logic [`SR_ADDR_W-1:0] pc;
    logic [`SR_ADDR_W-1:0] next_pc;
    logic [`SR_WORD_W-1:0] ir;

    //////////////////////////////////////////////////
    // program counter
    //////////////////////////////////////////////////

    assign next_pc = clear_pc ? start_pc : pc + 1'b1;

    always_ff @(posedge clk) begin
        if (load_pc) begin
            pc <= next_pc;
        end
    end

    assign mem_addr = pc;   // memory always reads at the pc

    // ir picks up the word read at the previous edge
    always_ff @(posedge clk) begin
        if (load_ir) begin
            ir <= mem_rdata;
        end
    end

    //////////////////////////////////////////////////
    // field decode
    //////////////////////////////////////////////////

    always_comb begin
        instr.opcode   = simple_risc_pkg::opcode_e'(ir[15:13]);
        instr.alu_op   = simple_risc_pkg::alu_op_e'(ir[12:11]);
        instr.shift_op = simple_risc_pkg::shift_op_e'(ir[4:3]);
        instr.rn       = ir[10:8];
        instr.rd       = ir[7:5];
        instr.rm       = ir[2:0];
        // sign extend the low byte
        instr.sximm8   = {{(`SR_WORD_W-8){ir[7]}}, ir[7:0]};
    end

    // fsm never fetches and advances the pc in one step
    a_ir_pc_apart: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load_ir && load_pc)
    );

endmodule

// File: source/simple_risc_pkg.sv
// simple risc shared types, instruction encodings, controls and status flags
`include "simple_risc_config.svh"

package simple_risc_pkg;

    typedef enum logic [2:0] {
        OP_ALU  = 3'b101,
        OP_MOV  = 3'b110,
        OP_HALT = 3'b111
    } opcode_e;               // instr[15:13]

    // instr[12:11]; for MOV 10 is the immediate form, 00 the register form
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_CMP = 2'b01,      // subtract, status only
        ALU_AND = 2'b10,
        ALU_MVN = 2'b11
    } alu_op_e;

    typedef enum logic [1:0] {
        SH_NONE = 2'b00,
        SH_LSL  = 2'b01,
        SH_LSR  = 2'b10,
        SH_ASR  = 2'b11
    } shift_op_e;             // instr[4:3]

    typedef enum logic [1:0] {
        REG_RM = 2'b00,
        REG_RD = 2'b01,
        REG_RN = 2'b10
    } reg_sel_e;

    typedef enum logic [3:0] {
        S_RESET,
        S_PC_UPDATE,
        S_FETCH_WAIT,
        S_LOAD_IR,
        S_DECODE,
        S_HALT,
        S_WRITE_IMM,          // MOV immediate into Rn
        S_LOAD_B,             // Rm into B
        S_LOAD_A,             // Rn into A
        S_CALC,               // C from A and shifted B
        S_CALC_ZA,            // C with A forced to zero
        S_WRITE_C,            // C into Rd
        S_LOAD_STATUS         // CMP flags only
    } cpu_state_e;

    typedef struct packed {
        opcode_e                   opcode;
        alu_op_e                   alu_op;
        shift_op_e                 shift_op;
        logic [`SR_REG_IDX_W-1:0]  rn;
        logic [`SR_REG_IDX_W-1:0]  rd;
        logic [`SR_REG_IDX_W-1:0]  rm;
        logic [`SR_WORD_W-1:0]     sximm8;
    } decoded_instr_t;

    typedef struct packed {
        reg_sel_e  reg_sel;
        logic      wb_imm;        // 1 writes sximm8 back, 0 writes C
        logic      reg_wr;
        logic      load_a;
        logic      load_b;
        logic      load_c;
        logic      load_status;
        logic      zero_a;
    } dp_ctrl_t;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } status_flags_t;

endpackage

// File: source/simple_risc_config.svh
// simple risc core configuration, word, address and register file sizes
`ifndef SIMPLE_RISC_CONFIG_SVH
`define SIMPLE_RISC_CONFIG_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

// data path and instruction word
`define SR_WORD_W 16

// memory address, also the pc width
`define SR_ADDR_W 8

//////////////////////////////////////////////////
// register file
//////////////////////////////////////////////////

`define SR_NUM_REGS 8

// must cover SR_NUM_REGS
`define SR_REG_IDX_W 3

`endif
